// ==== soc.f ====
soc_pkg.sv
tcb_dec.sv
soc_memory.sv
tcb_gpio.sv
tcb_timer.sv
soc_top.sv
tb_soc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the soc testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_soc_top -f soc.f 2>&1 | tee build.log

# the simulation may stop on $fatal, the log decides
./obj_dir/Vtb_soc_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// ==== tb_soc_top.sv ====
module tb_soc_top;

  timeunit 1ns;
  timeprecision 100ps;

  import soc_pkg::*;

  localparam int unsigned TEST_CYCLES = 1500;  // rough length of all tests together
  localparam int unsigned MEM_WORDS   = 64;    // random window, small so words get rewritten
  localparam adr_t        MEM_BASE    = 14'h2000;
  localparam adr_t        GPIO_BASE   = 14'h0000;
  localparam adr_t        TMR_BASE    = 14'h1000;

  logic     clk;
  logic     rst;
  tcb_req_t bus_req;
  dat_t     bus_rdt;
  gpio_t    gpio_o;
  gpio_t    gpio_e;
  gpio_t    gpio_i;
  logic     irq;

  dat_t  ref_mem [int];  // reference memory, by word index
  gpio_t ref_gpio_o;
  gpio_t ref_gpio_e;
  dat_t  exp_q [$];      // expected read data, oldest first
  dat_t  msk_q [$];      // bits to compare, 0 just captures
  string what_q [$];
  dat_t  last_rdt;       // last response seen by the compare process

  soc_top #(.AW(AW), .DW(DW), .GW(GW)) DUT (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rdt (bus_rdt),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .gpio_i  (gpio_i),
    .irq     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model and check
  ////////////////////////////////////////

  // new word from old word, write data and byte enables
  function automatic dat_t ref_merge(dat_t old, dat_t wdt, ben_t ben);
    dat_t res;
    for (int b = 0; b < BN; b++) begin
      res[8*b +: 8] = ben[b] ? wdt[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  // timer register once a oneshot run to compare c is over
  function automatic dat_t oneshot_expect(rof_t r, dat_t c);
    case (r)
      TMR_CTRL:         return dat_t'(2);  // oneshot kept, enable cleared
      TMR_CMP, TMR_CNT: return c;          // count frozen at compare
      default:          return dat_t'(1);  // status set
    endcase
  endfunction

  function automatic adr_t mem_adr(int widx);
    return MEM_BASE + adr_t'(widx * 4);
  endfunction

  task automatic check_eq(dat_t got, dat_t exp, string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // response of a read comes back one cycle after its transfer
  initial begin : compare
    logic  due;
    dat_t  exp;
    dat_t  msk;
    string what;
    due = 1'b0;
    forever begin
      @(negedge clk);
      if (due) begin
        if (exp_q.size() == 0) begin
          $display("a read response arrived with no expected value queued");
          $display("Testbench failed");
          $fatal(1);
        end
        exp      = exp_q.pop_front();
        msk      = msk_q.pop_front();
        what     = what_q.pop_front();
        last_rdt = bus_rdt;
        if (msk != '0) check_eq(bus_rdt & msk, exp & msk, what);
      end
      due = bus_req.vld & ~bus_req.wen;  // read in this cycle, answer next
    end
  end

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  task automatic drive(logic wen, adr_t adr, ben_t ben, dat_t wdt);
    tcb_req_t r;
    r.vld = 1'b1;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    @(posedge clk);
    bus_req <= r;
  endtask

  task automatic idle();
    @(posedge clk);
    bus_req.vld <= 1'b0;
  endtask

  task automatic bus_write(adr_t adr, dat_t wdt, ben_t ben);
    drive(1'b1, adr, ben, wdt);
  endtask

  task automatic issue_read(adr_t adr, dat_t exp, dat_t msk, string what);
    exp_q.push_back(exp);
    msk_q.push_back(msk);
    what_q.push_back(what);
    drive(1'b0, adr, '0, '0);
  endtask

  // idle until every read is answered
  task automatic flush();
    idle();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic read_check(adr_t adr, dat_t exp, string what);
    issue_read(adr, exp, '1, what);
    flush();
  endtask

  task automatic read_word(adr_t adr, output dat_t dat);
    issue_read(adr, '0, '0, "");
    flush();
    dat = last_rdt;
  endtask

  // wait for irq, n counts cycles
  task automatic wait_irq(int lim, output int n);
    n = 0;
    @(negedge clk);
    while (!irq && n < lim) begin
      @(negedge clk);
      n++;
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic random_memory();
    int   widx;
    int   wlist [$];
    dat_t wdt;
    ben_t ben;
    for (int i = 0; i < 200; i++) begin
      widx = $urandom_range(0, MEM_WORDS - 1);
      wdt  = $urandom;
      ben  = ben_t'($urandom);
      if (!ref_mem.exists(widx)) begin
        ben = '1;  // first write fills the word
        ref_mem[widx] = '0;
        wlist.push_back(widx);
      end
      bus_write(mem_adr(widx), wdt, ben);
      ref_mem[widx] = ref_merge(ref_mem[widx], wdt, ben);
      if ($urandom_range(0, 1) == 1) begin  // read right behind the write
        widx = wlist[$urandom_range(0, wlist.size() - 1)];
        issue_read(mem_adr(widx), ref_mem[widx], '1, "memory read");
      end
    end
    // bursts of reads on consecutive cycles
    for (int i = 0; i < 20; i++) begin
      for (int k = 0; k < 4; k++) begin
        widx = wlist[$urandom_range(0, wlist.size() - 1)];
        issue_read(mem_adr(widx), ref_mem[widx], '1, "back to back read");
      end
    end
    flush();
  endtask

  task automatic decode_map();
    dat_t vm;
    dat_t vg;
    dat_t vt;
    vm = $urandom;
    vg = ~vm;
    vt = vm ^ 32'h5a5a_5a5a;
    bus_write(MEM_BASE + 4, vm, '1);  // word 1 in each region
    ref_mem[1] = vm;
    ref_mem['h401] = ~vt;  // memory word a stray timer write would land on
    bus_write(mem_adr('h401), ref_mem['h401], '1);
    bus_write(GPIO_BASE + 4, vg, '1);
    ref_gpio_e = gpio_t'(vg);
    bus_write(TMR_BASE + 4, vt, '1);
    read_check(MEM_BASE + 4, vm, "decode memory");
    read_check(GPIO_BASE + 4, vg, "decode gpio");
    read_check(TMR_BASE + 4, vt, "decode timer");
    read_check(mem_adr('h401), ref_mem['h401], "memory after peripheral writes");
  endtask

  task automatic gpio_regs();
    dat_t wdt;
    ben_t ben;
    gpio_t gi;
    for (int r = 0; r < 2; r++) begin
      wdt = $urandom;
      ben = ben_t'($urandom);
      bus_write(GPIO_BASE + adr_t'(4*r), wdt, ben);
      if (r == 0) ref_gpio_o = gpio_t'(ref_merge(dat_t'(ref_gpio_o), wdt, ben));
      else        ref_gpio_e = gpio_t'(ref_merge(dat_t'(ref_gpio_e), wdt, ben));
      idle();
      @(negedge clk);  // one cycle after the transfer
      check_eq(dat_t'(gpio_o), dat_t'(ref_gpio_o), "gpio_o pins");
      check_eq(dat_t'(gpio_e), dat_t'(ref_gpio_e), "gpio_e pins");
    end
    read_check(GPIO_BASE, dat_t'(ref_gpio_o), "GPIO_OUT readback");
    read_check(GPIO_BASE + 4, dat_t'(ref_gpio_e), "GPIO_OE readback");
    gi = gpio_t'($urandom);
    @(posedge clk);
    gpio_i <= gi;
    repeat (2) @(posedge clk);  // through the synchronizer
    read_check(GPIO_BASE + 8, dat_t'(gi), "GPIO_IN readback");
  endtask

  task automatic periodic_timer();
    int   c;
    int   n;
    dat_t cnt;
    c = $urandom_range(4, 12);
    bus_write(TMR_BASE + 4, dat_t'(c), '1);
    bus_write(TMR_BASE, dat_t'(1), '1);  // enable, periodic
    idle();
    wait_irq(2 * (c + 2), n);
    check_eq(dat_t'(irq), dat_t'(1), "periodic irq rise");
    bus_write(TMR_BASE + 12, dat_t'(1), '1);  // clear status
    idle();
    wait_irq(2 * (c + 2), n);
    check_eq(dat_t'(irq), dat_t'(1), "periodic status again");
    check_eq(dat_t'(n <= c + 1), dat_t'(1), "status again within compare plus one");
    for (int i = 0; i < 2 * (c + 1); i++) begin
      read_word(TMR_BASE + 8, cnt);
      check_eq(dat_t'(cnt <= dat_t'(c)), dat_t'(1), "count above compare");
    end
    bus_write(TMR_BASE, '0, '1);  // stop, then clear
    bus_write(TMR_BASE + 12, dat_t'(1), '1);
    idle();
    @(negedge clk);
    check_eq(dat_t'(irq), '0, "irq after stop and clear");
  endtask

  task automatic oneshot_timer();
    int c;
    c = $urandom_range(4, 12);
    bus_write(TMR_BASE + 4, dat_t'(c), '1);
    bus_write(TMR_BASE, dat_t'(3), '1);  // enable, oneshot
    idle();
    repeat (c + 4) @(posedge clk);
    for (int r = 0; r < 4; r++) begin
      read_check(TMR_BASE + adr_t'(4*r), oneshot_expect(rof_t'(r), dat_t'(c)),
                 "oneshot register");
    end
    @(negedge clk);
    check_eq(dat_t'(irq), dat_t'(1), "oneshot irq");
    bus_write(TMR_BASE + 12, dat_t'(1), '1);
    idle();
    @(negedge clk);
    check_eq(dat_t'(irq), '0, "irq after status clear");
    read_check(TMR_BASE + 8, dat_t'(c), "oneshot count held");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    bus_req    = '0;
    gpio_i     = '0;
    ref_gpio_o = '0;
    ref_gpio_e = '0;
    last_rdt   = '0;
    void'($urandom(32'h66a3));
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_eq(dat_t'(gpio_o), '0, "gpio_o after reset");
    check_eq(dat_t'(gpio_e), '0, "gpio_e after reset");
    check_eq(dat_t'(irq), '0, "irq after reset");
    check_eq(bus_rdt, '0, "bus_rdt after reset");
    for (int r = 0; r < 4; r++) begin
      read_check(TMR_BASE + adr_t'(4*r), '0, "timer register after reset");
    end
    random_memory();
    decode_map();
    gpio_regs();
    periodic_timer();
    oneshot_timer();
    repeat (2) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

  initial begin : watchdog
    #(TEST_CYCLES * 4 * 2);
    $display("timeout, the tests did not finish within %0d cycles", TEST_CYCLES * 2);
    $display("Testbench failed");
    $fatal(1);
  end

endmodule

// ==== soc_top.sv ====
module soc_top #(
  parameter int unsigned AW = soc_pkg::AW,  // bus byte address width
  parameter int unsigned DW = soc_pkg::DW,  // bus data width
  parameter int unsigned GW = soc_pkg::GW   // gpio width
)(
  input  logic              clk,
  input  logic              rst,
  // load/store bus from the core
  input  soc_pkg::tcb_req_t bus_req,
  output soc_pkg::dat_t     bus_rdt,
  // gpio pins
  output soc_pkg::gpio_t    gpio_o,
  output soc_pkg::gpio_t    gpio_e,
  input  soc_pkg::gpio_t    gpio_i,
  // timer interrupt
  output logic              irq
);

  import soc_pkg::*;

  ////////////////////////////////////////
  // target buses
  ////////////////////////////////////////

  // port 0 memory, 1 gpio, 2 timer
  tcb_req_t      sub_req [PN];
  logic [DW-1:0] sub_rdt [PN];

  tcb_dec #(
    .PN      (PN)
  ) dec (
    .clk     (clk),
    .rst     (rst),
    .req     (bus_req),
    .rdt     (bus_rdt),
    .sub_req (sub_req),
    .sub_rdt (sub_rdt)
  );

  ////////////////////////////////////////
  // targets
  ////////////////////////////////////////

  // upper half of the space
  soc_memory #(
    .MAW  (AW-1)
  ) mem (
    .clk  (clk),
    .req  (sub_req[0]),
    .rdt  (sub_rdt[0])
  );

  tcb_gpio #(
    .GW     (GW)
  ) gpio (
    .clk    (clk),
    .rst    (rst),
    .req    (sub_req[1]),
    .rdt    (sub_rdt[1]),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  tcb_timer tmr (
    .clk  (clk),
    .rst  (rst),
    .req  (sub_req[2]),
    .rdt  (sub_rdt[2]),
    .irq  (irq)
  );

endmodule

// ==== tcb_timer.sv ====
module tcb_timer (
  input  logic              clk,
  input  logic              rst,
  // bus
  input  soc_pkg::tcb_req_t req,
  output soc_pkg::dat_t     rdt,
  // interrupt
  output logic              irq
);

  import soc_pkg::*;

  tmr_state_t state;
  logic [1:0] ctrl;    // {oneshot, enable}
  dat_t       cmp;     // compare value
  dat_t       cnt;     // counter
  logic       stat;    // compare reached
  logic       wr;
  logic       rd;
  rof_t       rof;
  logic       ctl_wr;  // TMR_CTRL write, low byte
  logic       cmp_wr;  // TMR_CMP write
  logic       clr_wr;  // write 1 to TMR_STAT bit 0
  logic       hit;     // count at compare

  assign wr     = req.vld &  req.wen;
  assign rd     = req.vld & ~req.wen;
  assign rof    = req.adr[3:2];
  assign ctl_wr = wr & (rof == TMR_CTRL) & req.ben[0];
  assign cmp_wr = wr & (rof == TMR_CMP);
  assign clr_wr = wr & (rof == TMR_STAT) & req.ben[0] & req.wdt[0];
  assign hit    = (cnt == cmp);

  ////////////////////////////////////////
  // mode FSM and counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TMR_IDLE;
      ctrl  <= '0;
      cnt   <= '0;
      stat  <= 1'b0;
    end else begin
      if (clr_wr) stat <= 1'b0;  // a new hit below wins
      case (state)
        TMR_RUN: begin
          if (hit) begin
            stat <= 1'b1;
            if (ctrl[TMR_OS]) begin
              ctrl[TMR_EN] <= 1'b0;  // oneshot, freeze at compare
              state        <= TMR_DONE;
            end else begin
              cnt <= '0;             // periodic wrap, period cmp+1
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        TMR_DONE: if (clr_wr) state <= TMR_IDLE;  // ack ends the oneshot
        default: ;                                // idle holds the count
      endcase
      // control writes override the counter step
      if (ctl_wr) begin
        ctrl <= req.wdt[1:0];
        if (req.wdt[TMR_EN]) begin
          cnt   <= '0;
          state <= TMR_RUN;
        end else begin
          state <= TMR_IDLE;  // count held
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)         cmp <= '0;
    else if (cmp_wr) cmp <= ben_merge(cmp, req.wdt, req.ben);
  end

  assign irq = stat;

  // read response
  always_ff @(posedge clk) begin
    if (rd) begin
      case (rof)
        TMR_CTRL: rdt <= DW'(ctrl);
        TMR_CMP:  rdt <= cmp;
        TMR_CNT:  rdt <= cnt;
        TMR_STAT: rdt <= DW'(stat);
      endcase
    end
  end

endmodule

// ==== tcb_gpio.sv ====
module tcb_gpio #(
  parameter int unsigned GW = soc_pkg::GW  // number of pins
)(
  input  logic              clk,
  input  logic              rst,
  // bus
  input  soc_pkg::tcb_req_t req,
  output soc_pkg::dat_t     rdt,
  // pins
  output soc_pkg::gpio_t    gpio_o,  // output value
  output soc_pkg::gpio_t    gpio_e,  // output enable
  input  soc_pkg::gpio_t    gpio_i
);

  import soc_pkg::*;

  logic [GW-1:0] gpio_s0;  // first sync stage
  logic [GW-1:0] gpio_s1;  // second sync stage, read by GPIO_IN
  logic          wr;
  logic          rd;
  rof_t          rof;

  assign wr  = req.vld &  req.wen;
  assign rd  = req.vld & ~req.wen;
  assign rof = req.adr[3:2];

  ////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_s0 <= '0;
      gpio_s1 <= '0;
    end else begin
      gpio_s0 <= gpio_i;
      gpio_s1 <= gpio_s0;
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (wr) begin
      case (rof)
        GPIO_OUT: gpio_o <= GW'(ben_merge(DW'(gpio_o), req.wdt, req.ben));
        GPIO_OE:  gpio_e <= GW'(ben_merge(DW'(gpio_e), req.wdt, req.ben));
        default: ;  // GPIO_IN is read only
      endcase
    end
  end

  // read response
  always_ff @(posedge clk) begin
    if (rd) begin
      case (rof)
        GPIO_OUT: rdt <= DW'(gpio_o);
        GPIO_OE:  rdt <= DW'(gpio_e);
        GPIO_IN:  rdt <= DW'(gpio_s1);
        default:  rdt <= '0;
      endcase
    end
  end

endmodule

// ==== soc_memory.sv ====
module soc_memory #(
  parameter int unsigned MAW = soc_pkg::AW-1  // memory byte address width
)(
  input  logic              clk,
  input  soc_pkg::tcb_req_t req,
  output soc_pkg::dat_t     rdt
);

  import soc_pkg::*;

  localparam int unsigned WO = $clog2(BN);   // byte offset bits in a word
  localparam int unsigned MD = 2**(MAW-WO);  // depth in words

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  dat_t              mem [MD];
  logic [MAW-WO-1:0] idx;  // word index

  assign idx = req.adr[MAW-1:WO];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (req.vld & req.wen) begin
      for (int b = 0; b < BN; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    if (req.vld & ~req.wen) begin
      rdt <= mem[idx];
    end
  end

endmodule

// ==== tcb_dec.sv ====
module tcb_dec #(
  parameter int unsigned PN = soc_pkg::PN  // number of targets
)(
  input  logic              clk,
  input  logic              rst,
  // from the load/store master
  input  soc_pkg::tcb_req_t req,
  output soc_pkg::dat_t     rdt,
  // to the targets
  output soc_pkg::tcb_req_t sub_req [PN],
  input  soc_pkg::dat_t     sub_rdt [PN]
);

  import soc_pkg::*;

  localparam int unsigned SW = (PN > 1) ? $clog2(PN) : 1;  // index width

  logic    [1:0] top;      // region bits of the address
  logic [PN-1:0] hit;      // per port address match
  logic [SW-1:0] sel_nxt;  // port index of this transfer
  logic [SW-1:0] sel;      // port of the last read
  logic          sel_vld;  // a read response exists

  assign top = req.adr[AW-1 -: 2];

  ////////////////////////////////////////
  // request fan-out
  ////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : gen_port
    assign hit[i] = ((top & DEC_MASK[i]) == DEC_MATCH[i]);
    always_comb begin
      sub_req[i]     = req;                // payload passes through
      sub_req[i].vld = req.vld & hit[i];   // only the matching port sees it
    end
  end

  // the map covers the whole space, exactly one hit
  always_comb begin
    sel_nxt = '0;
    for (int i = 0; i < PN; i++) begin
      if (hit[i]) sel_nxt = SW'(i);
    end
  end

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////

  // remember who answers the read, writes leave it alone
  always_ff @(posedge clk) begin
    if (rst) begin
      sel     <= '0;
      sel_vld <= 1'b0;
    end else if (req.vld & ~req.wen) begin
      sel     <= sel_nxt;
      sel_vld <= 1'b1;
    end
  end

  assign rdt = sel_vld ? sub_rdt[sel] : '0;  // zero until the first read

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

  ////////////////////////////////////////
  // bus widths and types
  ////////////////////////////////////////

  localparam int unsigned AW = 14;      // byte address width
  localparam int unsigned DW = 32;      // data width
  localparam int unsigned BN = DW/8;    // byte lanes
  localparam int unsigned GW = 32;      // gpio width

  typedef logic [AW-1:0] adr_t;
  typedef logic [DW-1:0] dat_t;
  typedef logic [BN-1:0] ben_t;
  typedef logic [GW-1:0] gpio_t;
  typedef logic    [1:0] rof_t;         // register word offset, adr[3:2]

  // load/store request, one transfer per cycle with vld
  typedef struct packed {
    logic vld;  // transfer valid
    logic wen;  // 1 write, 0 read
    adr_t adr;
    ben_t ben;
    dat_t wdt;
  } tcb_req_t;

  ////////////////////////////////////////
  // address map over adr[AW-1:AW-2]
  ////////////////////////////////////////

  localparam int unsigned PN = 3;
  // port 2 timer, port 1 gpio, port 0 memory
  localparam logic [PN-1:0][1:0] DEC_MATCH = {2'b01, 2'b00, 2'b10};
  localparam logic [PN-1:0][1:0] DEC_MASK  = {2'b11, 2'b11, 2'b10};

  // gpio registers
  localparam rof_t GPIO_OUT = 2'd0;
  localparam rof_t GPIO_OE  = 2'd1;
  localparam rof_t GPIO_IN  = 2'd2;

  // timer registers
  localparam rof_t TMR_CTRL = 2'd0;
  localparam rof_t TMR_CMP  = 2'd1;
  localparam rof_t TMR_CNT  = 2'd2;
  localparam rof_t TMR_STAT = 2'd3;

  localparam int unsigned TMR_EN = 0;  // ctrl enable bit
  localparam int unsigned TMR_OS = 1;  // ctrl oneshot bit

  typedef enum logic [1:0] {TMR_IDLE, TMR_RUN, TMR_DONE} tmr_state_t;

  // write data merged into old word under byte enables
  function automatic dat_t ben_merge(dat_t old, dat_t wdt, ben_t ben);
    dat_t res;
    res = old;
    for (int b = 0; b < BN; b++) begin
      if (ben[b]) res[8*b +: 8] = wdt[8*b +: 8];
    end
    return res;
  endfunction

endpackage
